// ==== Makefile ====
SIM  := obj_dir/Vtb_hwpe_ctrl
SRCS := $(shell grep -v '^+' files.f)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

$(SIM): files.f $(SRCS) include/tb_axil_tasks.svh dv/hwpe_ctrl_trace.txt
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_hwpe_ctrl

clean:
	rm -rf obj_dir

// ==== dv/hwpe_ctrl_trace.txt ====
# W byte_addr data strobe | R byte_addr expected | D engine done pulse
# S timed(1: two cycles after last write) job_word0 job_word1 job_word2 job_word3
R 004 00000000
W 100 11223344 f
W 100 aabbccdd 5
R 100 11bb33dd
W 104 00000055 1
W 140 99887766 c
R 140 99880000
R 100 11bb33dd
W 020 cafef00d 3
R 020 0000f00d
W 000 00000000 f
S 1 11bb33dd 00000055 00000000 00000000
R 00c 00000001
R 004 00000001
W 000 00000000 f
R 004 ffffffff
R 00c 00000101
D
S 0 99880000 00000000 00000000 00000000
R 00c 00000100
R 010 00000001
R 004 00000002
D
R 008 00000002
R 008 00000000
R 010 00000002
W 014 00000001 f
R 004 00000000
R 100 00000000
R 020 00000000
R 00c 00000000
R 010 00000000
R 018 deadbeef
R 01c deadbeef

// ==== include/tb_axil_tasks.svh ====
// AXI4-Lite master tasks
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Back-pressure of 0 to 3 cycles before taking a response
task automatic ready_delay();
  int n;
  n = $urandom_range(3, 0);
  repeat (n) begin
    @(posedge clk);
    #1;
  end
endtask

task automatic write_word(input logic [8:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
  axil_req.awaddr  = addr;
  axil_req.wdata   = data;
  axil_req.wstrb   = strb;
  axil_req.awvalid = 1'b1;
  axil_req.wvalid  = 1'b1;
  do @(negedge clk); while (!axil_rsp.awready);
  check_value("wready", 32'(axil_rsp.wready), 32'h1);
  last_wr_cyc = cyc; // Handshake completes on the coming edge
  @(posedge clk);
  #1;
  axil_req.awvalid = 1'b0;
  axil_req.wvalid  = 1'b0;
  ready_delay();
  axil_req.bready = 1'b1;
  do @(negedge clk); while (!axil_rsp.bvalid);
  check_value("bresp", 32'(axil_rsp.bresp), 32'h0);
  @(posedge clk);
  #1;
  axil_req.bready = 1'b0;
endtask

task automatic read_word(input logic [8:0] addr, output logic [31:0] data);
  axil_req.araddr  = addr;
  axil_req.arvalid = 1'b1;
  do @(negedge clk); while (!axil_rsp.arready);
  @(posedge clk);
  #1;
  axil_req.arvalid = 1'b0;
  ready_delay();
  axil_req.rready = 1'b1;
  do @(negedge clk); while (!axil_rsp.rvalid);
  data = axil_rsp.rdata;
  check_value("rresp", 32'(axil_rsp.rresp), 32'h0);
  @(posedge clk);
  #1;
  axil_req.rready = 1'b0;
endtask

`endif

// ==== dv/tb_hwpe_ctrl.sv ====
// HWPE control block testbench
`timescale 1ns/1ps

module tb_hwpe_ctrl
  import axil_pkg::*;
();

  localparam string TRACE = "dv/hwpe_ctrl_trace.txt";

  logic              clk;
  logic              rst_n;
  axil_req_t         axil_req;
  axil_rsp_t         axil_rsp;
  logic              engine_done;
  logic              engine_start;
  logic [3:0][31:0]  job_params;
  logic [1:0][31:0]  generic_params;

  int                n_checks;
  int                n_errors;
  int                cyc;
  int                limit;      // Watchdog limit in cycles
  int                last_wr_cyc;
  int                start_cyc[$];
  logic [3:0][31:0]  start_par[$];
  logic [1:0][31:0]  gen_exp;    // Expected generic register words

  hwpe_ctrl_top dut0 (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .axil_i           (axil_req),
    .axil_o           (axil_rsp),
    .engine_done_i    (engine_done),
    .engine_start_o   (engine_start),
    .job_params_o     (job_params),
    .generic_params_o (generic_params)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  `include "tb_axil_tasks.svh"

  // One-cycle done pulse from the engine model
  task automatic pulse_done();
    engine_done = 1'b1;
    @(posedge clk);
    #1;
    engine_done = 1'b0;
  endtask

  // Byte-merged generic words, zeroed by a soft clear write
  task automatic update_generic_model(input logic [8:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
    if (addr == 9'h014) begin
      gen_exp = '0;
    end else if (addr == 9'h020 || addr == 9'h024) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) gen_exp[addr[2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic run_trace(input int fd);
    string            line;
    byte              op;
    logic [31:0]      a;
    logic [31:0]      d;
    logic [31:0]      s;
    logic [31:0]      rd;
    logic [31:0]      w [4];
    logic [3:0][31:0] par;
    int               sc;
    int               n;
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n") continue;
      op = line[0];
      case (op)
        "W": begin
          n = $sscanf(line, "%c %h %h %h", op, a, d, s);
          if (n != 4) begin
            n_errors++;
            $display("Malformed write line in trace: %s", line);
          end
          write_word(a[8:0], d, s[3:0]);
          update_generic_model(a[8:0], d, s[3:0]);
          for (int g = 0; g < 2; g++) begin
            check_value($sformatf("generic_params_o[%0d]", g), generic_params[g], gen_exp[g]);
          end
        end
        "R": begin
          n = $sscanf(line, "%c %h %h", op, a, d);
          if (n != 3) begin
            n_errors++;
            $display("Malformed read line in trace: %s", line);
          end
          read_word(a[8:0], rd);
          check_value($sformatf("rdata[%03h]", a[8:0]), rd, d);
        end
        "D": pulse_done();
        "S": begin
          n = $sscanf(line, "%c %h %h %h %h %h", op, s, w[0], w[1], w[2], w[3]);
          if (n != 6) begin
            n_errors++;
            $display("Malformed start line in trace: %s", line);
          end
          while (start_cyc.size() == 0) @(negedge clk);
          sc  = start_cyc.pop_front();
          par = start_par.pop_front();
          if (s[0]) check_value("start delay", 32'(sc - last_wr_cyc), 32'd2);
          for (int i = 0; i < 4; i++) begin
            check_value($sformatf("job_params_o[%0d]", i), par[i], w[i]);
          end
          @(posedge clk);
          #1;
        end
        default: begin
          n_errors++;
          $display("Unknown operation in trace line: %s", line);
        end
      endcase
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Cycle count and watchdog
  always @(posedge clk) begin
    cyc++;
    if (limit != 0 && cyc > limit) begin
      $display("Timeout: trace did not finish within %0d cycles", limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Record every start together with the words the engine sees
  always @(negedge clk) begin
    if (rst_n && engine_start) begin
      start_cyc.push_back(cyc);
      start_par.push_back(job_params);
    end
  end

  initial begin
    int    fd;
    int    n_lines;
    string line;
    void'($urandom(74));
    rst_n       = 1'b0;
    axil_req    = '0;
    engine_done = 1'b0;
    gen_exp     = '0;
    n_checks    = 0;
    n_errors    = 0;
    cyc         = 0;
    limit       = 0;
    last_wr_cyc = 0;
    n_lines     = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fd = $fopen(TRACE, "r");
    if (fd == 0) begin
      n_errors++;
      $display("Cannot open trace file %s", TRACE);
    end else begin
      while ($fgets(line, fd) != 0) n_lines++;
      $fclose(fd);
      limit = cyc + n_lines * 60;
      fd = $fopen(TRACE, "r");
      run_trace(fd);
      $fclose(fd);
    end
    check_value("unclaimed starts", 32'(start_cyc.size()), 32'd0);
    $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
verilog/hwpe_ctrl_pkg.sv
verilog/axil_pkg.sv
verilog/axil_slave_port.sv
verilog/reg_access.sv
verilog/ctx_sched_fsm.sv
verilog/job_counters.sv
verilog/param_regfile.sv
verilog/hwpe_ctrl_top.sv
dv/tb_hwpe_ctrl.sv

// ==== verilog/axil_pkg.sv ====
// AXI4-Lite bus types
package axil_pkg;

  localparam int unsigned AXIL_AW = 9;  // Byte address
  localparam int unsigned AXIL_DW = 32;
  localparam int unsigned AXIL_SW = AXIL_DW / 8;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Master-driven signals
  typedef struct packed {
    logic [AXIL_AW-1:0] awaddr;
    logic               awvalid;
    logic [AXIL_DW-1:0] wdata;
    logic [AXIL_SW-1:0] wstrb;
    logic               wvalid;
    logic               bready;
    logic [AXIL_AW-1:0] araddr;
    logic               arvalid;
    logic               rready;
  } axil_req_t;

  // Slave-driven signals
  typedef struct packed {
    logic               awready;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               arready;
    logic               rvalid;
    logic [AXIL_DW-1:0] rdata;
    logic [1:0]         rresp;
  } axil_rsp_t;

endpackage

// ==== verilog/axil_slave_port.sv ====
// AXI4-Lite slave port
`timescale 1ns/1ps

module axil_slave_port
  import axil_pkg::*;
  import hwpe_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  axil_req_t   axil_i,
  output axil_rsp_t   axil_o,
  output reg_req_t    req_o,
  input  logic [31:0] rdata_i
);

  logic        b_pend_q;
  logic        r_pend_q;
  logic        r_first_q; // First cycle of a read response
  logic [31:0] rdata_q;
  logic        idle;
  logic        wr_acc;
  logic        rd_acc;

  // Nothing new while any response is held
  assign idle   = ~b_pend_q & ~r_pend_q;
  assign wr_acc = idle & axil_i.awvalid & axil_i.wvalid;
  assign rd_acc = idle & axil_i.arvalid & ~wr_acc; // Write wins a tie

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_pend_q  <= 1'b0;
      r_pend_q  <= 1'b0;
      r_first_q <= 1'b0;
    end else begin
      r_first_q <= rd_acc;
      if (wr_acc) begin
        b_pend_q <= 1'b1;
      end else if (axil_i.bready) begin
        b_pend_q <= 1'b0;
      end
      if (rd_acc) begin
        r_pend_q <= 1'b1;
      end else if (axil_i.rready) begin
        r_pend_q <= 1'b0;
      end
    end
  end

  // Decoder data is only valid in the first response cycle
  always_ff @(posedge clk_i) begin
    if (r_first_q) begin
      rdata_q <= rdata_i;
    end
  end

  assign req_o.valid = wr_acc | rd_acc;
  assign req_o.we    = wr_acc;
  assign req_o.addr  = wr_acc ? axil_i.awaddr[AXIL_AW-1:2] : axil_i.araddr[AXIL_AW-1:2];
  assign req_o.wdata = axil_i.wdata;
  assign req_o.be    = axil_i.wstrb;

  assign axil_o.awready = wr_acc;
  assign axil_o.wready  = wr_acc;
  assign axil_o.bvalid  = b_pend_q;
  assign axil_o.bresp   = RESP_OKAY;
  assign axil_o.arready = rd_acc;
  assign axil_o.rvalid  = r_pend_q;
  assign axil_o.rdata   = r_first_q ? rdata_i : rdata_q;
  assign axil_o.rresp   = RESP_OKAY;

  // Responses hold until the master takes them
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_o.bvalid && !axil_i.bready |=> axil_o.bvalid);
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_o.rvalid && !axil_i.rready |=> axil_o.rvalid && $stable(axil_o.rdata));

endmodule

// ==== verilog/ctx_sched_fsm.sv ====
// Context scheduler FSM
`timescale 1ns/1ps

module ctx_sched_fsm
  import hwpe_ctrl_pkg::*;
#(
  parameter int unsigned N_CONTEXT = 2
)
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  sched_cmd_t  cmd_i,
  input  logic        engine_done_i,
  output logic        engine_start_o,
  output logic        full_o,
  output logic [1:0]  running_ctx_o,
  output logic        job_done_o,
  output logic [31:0] status_o
);

  localparam logic [1:0] LAST_CTX = 2'(N_CONTEXT - 1);

  sched_state_t            state_q;
  sched_state_t            state_d;
  logic [1:0]              ptr_q;  // Next context to be triggered
  logic [1:0]              run_q;  // Context the engine works on
  logic [2:0]              cnt_q;  // Pending jobs
  logic [MAX_CONTEXTS-1:0] busy_q;
  logic                    done;

  assign done           = (state_q == RUNNING) & engine_done_i;
  assign job_done_o     = done;
  assign engine_start_o = (state_q == START);
  assign full_o         = (cnt_q == 3'(N_CONTEXT));
  assign running_ctx_o  = run_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (cnt_q != '0) state_d = START;
      START:   state_d = RUNNING;
      RUNNING: if (engine_done_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ptr_q   <= '0;
      run_q   <= '0;
      cnt_q   <= '0;
      busy_q  <= '0;
    end else if (cmd_i.soft_clear) begin
      state_q <= IDLE;
      ptr_q   <= '0;
      run_q   <= '0;
      cnt_q   <= '0;
      busy_q  <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_q + {2'b0, cmd_i.trigger} - {2'b0, done};
      if (cmd_i.trigger) begin
        busy_q[ptr_q] <= 1'b1;
        ptr_q         <= (ptr_q == LAST_CTX) ? 2'd0 : ptr_q + 2'd1;
      end
      // Full blocks any trigger into the running slot
      if (done) begin
        busy_q[run_q] <= 1'b0;
        run_q         <= (run_q == LAST_CTX) ? 2'd0 : run_q + 2'd1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < MAX_CONTEXTS; i++) begin
      status_o[8*i +: 8] = {7'b0, busy_q[i]};
    end
  end

  // A start always has a queued job behind it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    engine_start_o |-> (full_o || cnt_q != '0));

endmodule

// ==== verilog/hwpe_ctrl_pkg.sv ====
// HWPE control register map
package hwpe_ctrl_pkg;

  // Mandatory register word indices
  localparam logic [5:0] REG_TRIGGER     = 6'd0;
  localparam logic [5:0] REG_ACQUIRE     = 6'd1;
  localparam logic [5:0] REG_FINISHED    = 6'd2;
  localparam logic [5:0] REG_STATUS      = 6'd3;
  localparam logic [5:0] REG_RUNNING_JOB = 6'd4;
  localparam logic [5:0] REG_SOFT_CLEAR  = 6'd5;

  localparam logic [5:0] REG_GENERIC_BASE = 6'd8; // 6 and 7 stay unmapped

  localparam logic [31:0] RESP_ALL_CXT_BUSY = 32'hFFFF_FFFF;
  localparam logic [31:0] RDATA_UNMAPPED    = 32'hDEAD_BEEF;

  localparam int unsigned MAX_CONTEXTS = 4; // Status word holds one byte per context

  typedef struct packed {
    logic       is_job;
    logic [5:0] index;
  } global_addr_t;

  typedef struct packed {
    logic       is_job;
    logic [1:0] ctx;
    logic [3:0] param;
  } job_addr_t;

  // Top bit of the word address picks the view
  typedef union packed {
    global_addr_t glob;
    job_addr_t    job;
  } reg_addr_u;

  typedef struct packed {
    logic        valid;
    logic        we;
    reg_addr_u   addr;
    logic [31:0] wdata;
    logic [3:0]  be;
  } reg_req_t;

  typedef struct packed {
    logic trigger;
    logic soft_clear;
  } sched_cmd_t;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    START   = 2'd1,
    RUNNING = 2'd2
  } sched_state_t;

endpackage

// ==== verilog/hwpe_ctrl_top.sv ====
// HWPE control block top level
`timescale 1ns/1ps

module hwpe_ctrl_top
  import axil_pkg::*;
  import hwpe_ctrl_pkg::*;
#(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
)
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  axil_req_t                       axil_i,
  output axil_rsp_t                       axil_o,
  input  logic                            engine_done_i,
  output logic                            engine_start_o,
  output logic [N_IO_REGS-1:0][31:0]      job_params_o,
  output logic [N_GENERIC_REGS-1:0][31:0] generic_params_o
);

  reg_req_t    req;
  sched_cmd_t  cmd;
  logic [31:0] reg_rdata;
  logic [31:0] param_rdata;
  logic [31:0] status;
  logic        full;
  logic        acquire_grant;
  logic        finished_clr;
  logic        job_done;
  logic [1:0]  running_ctx;
  logic [1:0]  finished_cnt;
  logic [7:0]  offload_id;
  logic [7:0]  running_id;

  axil_slave_port u_port (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .axil_i  (axil_i),
    .axil_o  (axil_o),
    .req_o   (req),
    .rdata_i (reg_rdata)
  );

  reg_access u_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req),
    .rdata_o         (reg_rdata),
    .cmd_o           (cmd),
    .full_i          (full),
    .status_i        (status),
    .offload_id_i    (offload_id),
    .running_id_i    (running_id),
    .finished_cnt_i  (finished_cnt),
    .acquire_grant_o (acquire_grant),
    .finished_clr_o  (finished_clr),
    .param_rdata_i   (param_rdata)
  );

  ctx_sched_fsm #(
    .N_CONTEXT (N_CONTEXT)
  ) u_sched (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_i          (cmd),
    .engine_done_i  (engine_done_i),
    .engine_start_o (engine_start_o),
    .full_o         (full),
    .running_ctx_o  (running_ctx),
    .job_done_o     (job_done),
    .status_o       (status)
  );

  job_counters u_cnt (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (cmd.soft_clear),
    .acquire_grant_i (acquire_grant),
    .job_done_i      (job_done),
    .finished_clr_i  (finished_clr),
    .offload_id_o    (offload_id),
    .running_id_o    (running_id),
    .finished_cnt_o  (finished_cnt)
  );

  param_regfile #(
    .N_CONTEXT      (N_CONTEXT),
    .N_IO_REGS      (N_IO_REGS),
    .N_GENERIC_REGS (N_GENERIC_REGS)
  ) u_params (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (cmd.soft_clear), // Soft clear wipes stored parameters too
    .req_i            (req),
    .running_ctx_i    (running_ctx),
    .rdata_o          (param_rdata),
    .job_params_o     (job_params_o),
    .generic_params_o (generic_params_o)
  );

endmodule

// ==== verilog/job_counters.sv ====
// Job ID and finished counters
`timescale 1ns/1ps

module job_counters (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       acquire_grant_i,
  input  logic       job_done_i,
  input  logic       finished_clr_i,
  output logic [7:0] offload_id_o,
  output logic [7:0] running_id_o,
  output logic [1:0] finished_cnt_o
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_o   <= '0;
      running_id_o   <= '0;
      finished_cnt_o <= '0;
    end else if (clear_i) begin
      offload_id_o   <= '0;
      running_id_o   <= '0;
      finished_cnt_o <= '0;
    end else begin
      if (acquire_grant_i) begin
        offload_id_o <= offload_id_o + 8'd1; // Wraps at 256
      end
      if (job_done_i) begin
        running_id_o <= running_id_o + 8'd1;
      end
      // Read clear beats a done in the same cycle
      if (finished_clr_i) begin
        finished_cnt_o <= '0;
      end else if (job_done_i && finished_cnt_o < 2'd2) begin
        finished_cnt_o <= finished_cnt_o + 2'd1;
      end
    end
  end

endmodule

// ==== verilog/param_regfile.sv ====
// Job and generic parameter storage
`timescale 1ns/1ps

module param_regfile
  import hwpe_ctrl_pkg::*;
#(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
)
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  reg_req_t                       req_i,
  input  logic [1:0]                     running_ctx_i,
  output logic [31:0]                    rdata_o,
  output logic [N_IO_REGS-1:0][31:0]      job_params_o,
  output logic [N_GENERIC_REGS-1:0][31:0] generic_params_o
);

  logic [N_CONTEXT-1:0][N_IO_REGS-1:0][31:0] job_q;
  logic [N_GENERIC_REGS-1:0][31:0]           gen_q;
  logic                                      job_sel;
  logic                                      wr_en;

  assign job_sel = req_i.addr.job.is_job;
  assign wr_en   = req_i.valid & req_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      job_q <= '0;
      gen_q <= '0;
    end else if (clear_i) begin
      job_q <= '0;
      gen_q <= '0;
    end else if (wr_en) begin
      for (int c = 0; c < N_CONTEXT; c++) begin
        for (int p = 0; p < N_IO_REGS; p++) begin
          for (int b = 0; b < 4; b++) begin
            if (job_sel && req_i.addr.job.ctx == c && req_i.addr.job.param == p && req_i.be[b])
              job_q[c][p][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      for (int g = 0; g < N_GENERIC_REGS; g++) begin
        for (int b = 0; b < 4; b++) begin
          if (!job_sel && req_i.addr.glob.index == REG_GENERIC_BASE + g && req_i.be[b])
            gen_q[g][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Out-of-range addresses read as unmapped
  always_comb begin
    rdata_o = RDATA_UNMAPPED;
    for (int c = 0; c < N_CONTEXT; c++) begin
      for (int p = 0; p < N_IO_REGS; p++) begin
        if (job_sel && req_i.addr.job.ctx == c && req_i.addr.job.param == p)
          rdata_o = job_q[c][p];
      end
    end
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      if (!job_sel && req_i.addr.glob.index == REG_GENERIC_BASE + g)
        rdata_o = gen_q[g];
    end
  end

  always_comb begin
    job_params_o = job_q[0];
    for (int c = 1; c < N_CONTEXT; c++) begin
      if (running_ctx_i == c) job_params_o = job_q[c];
    end
  end

  assign generic_params_o = gen_q;

endmodule

// ==== verilog/reg_access.sv ====
// Register access decoder
`timescale 1ns/1ps

module reg_access
  import hwpe_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  reg_req_t    req_i,
  output logic [31:0] rdata_o,
  output sched_cmd_t  cmd_o,
  input  logic        full_i,
  input  logic [31:0] status_i,
  input  logic [7:0]  offload_id_i,
  input  logic [7:0]  running_id_i,
  input  logic [1:0]  finished_cnt_i,
  output logic        acquire_grant_o,
  output logic        finished_clr_o,
  input  logic [31:0] param_rdata_i
);

  logic        is_rd;
  logic        is_wr;
  logic [31:0] rdata_d;

  assign is_rd = req_i.valid & ~req_i.we;
  assign is_wr = req_i.valid & req_i.we;

  always_comb begin
    rdata_d         = RDATA_UNMAPPED;
    cmd_o           = '0;
    acquire_grant_o = 1'b0;
    finished_clr_o  = 1'b0;
    if (req_i.addr.job.is_job || req_i.addr.glob.index >= REG_GENERIC_BASE) begin
      rdata_d = param_rdata_i; // Storage decodes its own range
    end else begin
      case (req_i.addr.glob.index)
        REG_TRIGGER: begin
          rdata_d       = '0;
          cmd_o.trigger = is_wr & ~full_i; // Dropped when every context is pending
        end
        REG_ACQUIRE: begin
          if (full_i) begin
            rdata_d = RESP_ALL_CXT_BUSY;
          end else begin
            rdata_d         = {24'b0, offload_id_i};
            acquire_grant_o = is_rd;
          end
        end
        REG_FINISHED: begin
          rdata_d        = {30'b0, finished_cnt_i};
          finished_clr_o = is_rd; // Cleared by reading
        end
        REG_STATUS:      rdata_d = status_i;
        REG_RUNNING_JOB: rdata_d = {24'b0, running_id_i};
        REG_SOFT_CLEAR: begin
          rdata_d          = '0;
          cmd_o.soft_clear = is_wr;
        end
        default: rdata_d = RDATA_UNMAPPED;
      endcase
    end
  end

  // Read data one cycle after the access
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (is_rd) begin
      rdata_o <= rdata_d;
    end
  end

endmodule
